// ==== include/tiled_ram_macros.svh ====
// -------------------------------------------------------------------
// TILES must equal FANOUT raised to a whole power, and TILES must divide DEPTH
// The APB port decodes word addresses from an 8-bit byte address, so DEPTH is 64 at most
// -------------------------------------------------------------------
`ifndef TILED_RAM_MACROS_SVH
`define TILED_RAM_MACROS_SVH

// Base configuration
`define RAM_DEPTH 64
`define RAM_TILES 8
`define RAM_FANOUT 2
`define RAM_DATA_WIDTH 32

// Derived widths
`define RAM_ADDR_WIDTH ($clog2(`RAM_DEPTH))
`define RAM_TILE_ADDR_WIDTH ($clog2(`RAM_DEPTH / `RAM_TILES))
// Decoder stages, with decoder latency one less than this
`define RAM_STAGES ($clog2(`RAM_TILES) / $clog2(`RAM_FANOUT))

`endif

// ==== logic/apb_ram_port.sv ====
// -------------------------------------------------------------------
// One outstanding transfer without PSTRB or PPROT
// Misaligned byte addresses end with PSLVERR in the first access cycle
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "tiled_ram_macros.svh"

module apb_ram_port (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [7:0]                       paddr,
  input  logic [`RAM_DATA_WIDTH-1:0]       pwdata,
  output logic [`RAM_DATA_WIDTH-1:0]       prdata,
  output logic                             pready,
  output logic                             pslverr,
  output logic                             req_valid,
  output logic [`RAM_ADDR_WIDTH-1:0]       req_addr,
  output tiled_ram_pkg::ram_req_t          req_payload,
  input  tiled_ram_pkg::tile_rsp_t         rsp
);

  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_pending = 2'd1,
    st_error   = 2'd2
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   misaligned;
  logic   access;

  assign misaligned = |paddr[1:0];
  assign access     = psel && penable;

  // -------------------------------------------------------------------
  // Transfer FSM
  // -------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        // Error seen in setup is answered in the access cycle
        if (psel && misaligned) begin
          state_d = st_error;
        end else if (access) begin
          state_d = st_pending;
        end
      end
      st_pending: begin
        if (rsp.done) begin
          state_d = st_idle;
        end
      end
      st_error: begin
        if (access) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Single issue in the first access cycle while pending blocks a second one
  assign req_valid         = (state_q == st_idle) && access && !misaligned;
  assign req_addr          = paddr[`RAM_ADDR_WIDTH+1:2];
  assign req_payload.write = pwrite;
  assign req_payload.wdata = pwdata;

  // Completion
  assign pready  = ((state_q == st_pending) && rsp.done) || ((state_q == st_error) && access);
  assign pslverr = (state_q == st_error) && access;
  // Writes return zero
  assign prdata  = ((state_q == st_pending) && rsp.done && !pwrite) ? rsp.rdata : '0;

endmodule : apb_ram_port

`default_nettype wire

// ==== logic/apb_tiled_ram.sv ====
// -------------------------------------------------------------------
// Word access APB slave RAM with a fixed latency of three wait cycles
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "tiled_ram_macros.svh"

module apb_tiled_ram (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [7:0]                 paddr,
  input  logic [`RAM_DATA_WIDTH-1:0] pwdata,
  output logic [`RAM_DATA_WIDTH-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr
);

  import tiled_ram_pkg::*;

  // -------------------------------------------------------------------
  // Request path
  // -------------------------------------------------------------------
  logic                         req_valid;
  logic [`RAM_ADDR_WIDTH-1:0]   req_addr;
  ram_req_t                     req_payload;
  tile_req_t [`RAM_TILES-1:0]   tile_req;

  // Response path and the collision flag watched by the checker
  tile_rsp_t [`RAM_TILES-1:0]   tile_rsp;
  tile_rsp_t                    rsp;
  logic                         collision;

  apb_ram_port apb_ram_port_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_payload(req_payload),
    .rsp        (rsp)
  );

  ram_addr_decoder_tree #(
    .payload_t(ram_req_t)
  ) ram_addr_decoder_tree_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid   (req_valid),
    .addr    (req_addr),
    .payload (req_payload),
    .tile_req(tile_req)
  );

  // One tile per decoder leaf
  for (genvar t = 0; t < `RAM_TILES; t++) begin : gen_tile
    ram_tile ram_tile_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .tile_req(tile_req[t]),
      .tile_rsp(tile_rsp[t])
    );
  end

  ram_read_collector ram_read_collector_inst (
    .tile_rsp (tile_rsp),
    .rsp      (rsp),
    .collision(collision)
  );

endmodule : apb_tiled_ram

`default_nettype wire

// ==== logic/ram_addr_decoder.sv ====
// -------------------------------------------------------------------
// fanout must be a power of two of at least 2
// Registered outputs add one cycle; payload is held only with a valid
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ram_addr_decoder #(
  parameter int in_addr_width = 2,
  parameter int fanout = 2,
  parameter bit register_outputs = 1'b1,
  parameter type payload_t = logic,
  localparam int sel_width = $clog2(fanout),
  localparam int out_addr_width = in_addr_width - sel_width
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  in_valid,
  input  logic [in_addr_width-1:0]              in_addr,
  input  payload_t                              in_payload,
  output logic [fanout-1:0]                     out_valid,
  output logic [fanout-1:0][out_addr_width-1:0] out_addr,
  output payload_t [fanout-1:0]                 out_payload
);

  // Top address bits pick the lane
  logic [sel_width-1:0] sel;
  logic [fanout-1:0]    nxt_valid;

  assign sel = in_addr[in_addr_width-1 -: sel_width];

  always_comb begin
    for (int i = 0; i < fanout; i++) begin
      nxt_valid[i] = in_valid && (sel == sel_width'(i));
    end
  end

  if (register_outputs) begin : gen_reg
    // Lane valids
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        out_valid <= '0;
      end else begin
        out_valid <= nxt_valid;
      end
    end

    // Address remainder and payload only move on the chosen lane
    always_ff @(posedge clk) begin
      for (int i = 0; i < fanout; i++) begin
        if (nxt_valid[i]) begin
          out_addr[i]    <= in_addr[out_addr_width-1:0];
          out_payload[i] <= in_payload;
        end
      end
    end
  end else begin : gen_comb
    // Last stage goes straight through to the tiles
    always_comb begin
      out_valid = nxt_valid;
      for (int i = 0; i < fanout; i++) begin
        out_addr[i]    = in_addr[out_addr_width-1:0];
        out_payload[i] = in_payload;
      end
    end
  end

endmodule : ram_addr_decoder

`default_nettype wire

// ==== logic/ram_addr_decoder_tree.sv ====
// -------------------------------------------------------------------
// RAM_TILES must be RAM_FANOUT to a whole power
// Latency is RAM_STAGES - 1 cycles as the last stage is combinational
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "tiled_ram_macros.svh"

module ram_addr_decoder_tree #(
  parameter type payload_t = tiled_ram_pkg::ram_req_t
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        valid,
  input  logic [`RAM_ADDR_WIDTH-1:0]                  addr,
  input  payload_t                                    payload,
  output tiled_ram_pkg::tile_req_t [`RAM_TILES-1:0]   tile_req
);

  localparam int addr_width = `RAM_ADDR_WIDTH;
  localparam int tiles = `RAM_TILES;
  localparam int fanout = `RAM_FANOUT;
  localparam int stages = `RAM_STAGES;
  localparam int tile_addr_width = `RAM_TILE_ADDR_WIDTH;

  // -------------------------------------------------------------------
  // Stage wiring
  // -------------------------------------------------------------------

  // Full-size grid of stages by lanes where early stages use only a few lanes
  logic [stages-1:0][tiles-1:0]                  stage_in_valid;
  logic [stages-1:0][tiles-1:0][addr_width-1:0]  stage_in_addr;
  payload_t [stages-1:0][tiles-1:0]              stage_in_payload;
  logic [stages-1:0][tiles-1:0]                  stage_out_valid;
  logic [stages-1:0][tiles-1:0][addr_width-1:0]  stage_out_addr;
  payload_t [stages-1:0][tiles-1:0]              stage_out_payload;

  for (genvar s = 0; s < stages; s++) begin : gen_stage
    localparam int in_lanes = fanout ** s;
    localparam int out_lanes = fanout ** (s + 1);
    localparam int in_width = addr_width - $clog2(in_lanes);
    localparam int out_width = addr_width - $clog2(out_lanes);
    localparam int pad_width = addr_width - out_width;

    // Per-lane decoder outputs with the narrow address
    logic [in_lanes-1:0][fanout-1:0]                local_out_valid;
    logic [in_lanes-1:0][fanout-1:0][out_width-1:0] local_out_addr;
    payload_t [in_lanes-1:0][fanout-1:0]            local_out_payload;

    for (genvar il = 0; il < in_lanes; il++) begin : gen_lane
      // First stage takes the request, later ones the previous outputs
      if (s == 0) begin : gen_first
        assign stage_in_valid[s][il]   = valid;
        assign stage_in_addr[s][il]    = addr;
        assign stage_in_payload[s][il] = payload;
      end else begin : gen_next
        assign stage_in_valid[s][il]   = stage_out_valid[s-1][il];
        assign stage_in_addr[s][il]    = stage_out_addr[s-1][il];
        assign stage_in_payload[s][il] = stage_out_payload[s-1][il];
      end

      ram_addr_decoder #(
        .in_addr_width   (in_width),
        .fanout          (fanout),
        .register_outputs(s < (stages - 1)),
        .payload_t       (payload_t)
      ) ram_addr_decoder_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (stage_in_valid[s][il]),
        .in_addr    (stage_in_addr[s][il][in_width-1:0]),
        .in_payload (stage_in_payload[s][il]),
        .out_valid  (local_out_valid[il]),
        .out_addr   (local_out_addr[il]),
        .out_payload(local_out_payload[il])
      );

      // Output lane il*fanout+fo is zero-padded back to full width
      for (genvar fo = 0; fo < fanout; fo++) begin : gen_fanout
        localparam int out_lane = (il * fanout) + fo;

        assign stage_out_valid[s][out_lane]   = local_out_valid[il][fo];
        assign stage_out_addr[s][out_lane]    = {{pad_width{1'b0}}, local_out_addr[il][fo]};
        assign stage_out_payload[s][out_lane] = local_out_payload[il][fo];
      end
    end

    // Unused lanes of this stage
    for (genvar il = in_lanes; il < tiles; il++) begin : gen_in_tieoff
      assign stage_in_valid[s][il]   = 1'b0;
      assign stage_in_addr[s][il]    = '0;
      assign stage_in_payload[s][il] = '0;
    end

    for (genvar ol = out_lanes; ol < tiles; ol++) begin : gen_out_tieoff
      assign stage_out_valid[s][ol]   = 1'b0;
      assign stage_out_addr[s][ol]    = '0;
      assign stage_out_payload[s][ol] = '0;
    end
  end

  // -------------------------------------------------------------------
  // One lane per tile
  // -------------------------------------------------------------------
  for (genvar t = 0; t < tiles; t++) begin : gen_tile_out
    assign tile_req[t].valid = stage_out_valid[stages-1][t];
    assign tile_req[t].addr  = stage_out_addr[stages-1][t][tile_addr_width-1:0];
    assign tile_req[t].req   = stage_out_payload[stages-1][t];
  end

endmodule : ram_addr_decoder_tree

`default_nettype wire

// ==== logic/ram_read_collector.sv ====
// -------------------------------------------------------------------
// Purely combinational merge of tile completions
// At most one tile is expected to complete per cycle
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "tiled_ram_macros.svh"

module ram_read_collector (
  input  tiled_ram_pkg::tile_rsp_t [`RAM_TILES-1:0] tile_rsp,
  output tiled_ram_pkg::tile_rsp_t                  rsp,
  output logic                                      collision
);

  logic [`RAM_TILES-1:0]      done_vec;
  logic [`RAM_DATA_WIDTH-1:0] rdata_or;

  // Gather done bits
  for (genvar t = 0; t < `RAM_TILES; t++) begin : gen_done
    assign done_vec[t] = tile_rsp[t].done;
  end

  // Only tiles that completed contribute data
  always_comb begin
    rdata_or = '0;
    for (int t = 0; t < `RAM_TILES; t++) begin
      if (tile_rsp[t].done) begin
        rdata_or = rdata_or | tile_rsp[t].rdata;
      end
    end
  end

  assign rsp.done  = |done_vec;
  assign rsp.rdata = rdata_or;

  // More than one bit set clears to nonzero after x & (x-1)
  assign collision = |(done_vec & (done_vec - 1'b1));

endmodule : ram_read_collector

`default_nettype wire

// ==== logic/ram_tile.sv ====
// -------------------------------------------------------------------
// Register array tile with contents undefined until written
// Done pulses one cycle after a valid request and a read returns the old word
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "tiled_ram_macros.svh"

module ram_tile (
  input  logic                     clk,
  input  logic                     rst_n,
  input  tiled_ram_pkg::tile_req_t tile_req,
  output tiled_ram_pkg::tile_rsp_t tile_rsp
);

  localparam int tile_depth = `RAM_DEPTH / `RAM_TILES;

  logic [`RAM_DATA_WIDTH-1:0] mem [tile_depth];
  logic [`RAM_DATA_WIDTH-1:0] rdata_q;
  logic                       done_q;

  // Completion flag
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else begin
      done_q <= tile_req.valid;
    end
  end

  // Storage and read register
  always_ff @(posedge clk) begin
    if (tile_req.valid) begin
      if (tile_req.req.write) begin
        mem[tile_req.addr] <= tile_req.req.wdata;
      end else begin
        rdata_q <= mem[tile_req.addr];
      end
    end
  end

  assign tile_rsp.done  = done_q;
  assign tile_rsp.rdata = rdata_q;

endmodule : ram_tile

`default_nettype wire

// ==== logic/tiled_ram_pkg.sv ====
// -------------------------------------------------------------------
// Struct widths follow the tiled RAM macros header
// -------------------------------------------------------------------
`default_nettype none

`include "tiled_ram_macros.svh"

package tiled_ram_pkg;

  // -------------------------------------------------------------------
  // Request side
  // -------------------------------------------------------------------

  // Sideband that travels with the address through the decoder tree
  typedef struct packed {
    logic                       write;
    logic [`RAM_DATA_WIDTH-1:0] wdata;
  } ram_req_t;

  // One request lane as seen by a single tile
  typedef struct packed {
    logic                            valid;
    logic [`RAM_TILE_ADDR_WIDTH-1:0] addr;
    ram_req_t                        req;
  } tile_req_t;

  // -------------------------------------------------------------------
  // Response side
  // -------------------------------------------------------------------

  // Tile completion, also used for the merged response
  typedef struct packed {
    logic                       done;
    logic [`RAM_DATA_WIDTH-1:0] rdata;
  } tile_rsp_t;

endpackage : tiled_ram_pkg

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the APB tiled RAM testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_apb_tiled_ram -o tb_apb_tiled_ram_sim \
  && ./obj_dir/tb_apb_tiled_ram_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "Build or run returned an error status"
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log \
  && echo "Run passed" \
  || { echo "Run did not pass"; exit 1; }

// ==== tb.f ====
+incdir+include
logic/tiled_ram_pkg.sv
logic/ram_addr_decoder.sv
logic/ram_addr_decoder_tree.sv
logic/ram_tile.sv
logic/ram_read_collector.sv
logic/apb_ram_port.sv
logic/apb_tiled_ram.sv
tb/apb_tiled_ram_assert.sv
tb/tb_apb_tiled_ram.sv

// ==== tb/apb_tiled_ram_assert.sv ====
// -------------------------------------------------------------------
// Bound into apb_tiled_ram and expects one APB transfer at a time
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "tiled_ram_macros.svh"

module apb_tiled_ram_assert (
  input logic                                       clk,
  input logic                                       rst_n,
  input logic                                       psel,
  input logic                                       penable,
  input logic                                       pready,
  input logic                                       pslverr,
  input logic [7:0]                                 paddr,
  input tiled_ram_pkg::tile_req_t [`RAM_TILES-1:0]  tile_req,
  input logic                                       collision
);

  // Decoder latency plus the tile register
  localparam int ready_delay = `RAM_STAGES;

  // Count of failed assertions
  int unsigned fail_count = 0;

  logic [`RAM_TILES-1:0] tile_valid;
  logic                  access;
  logic                  in_transfer_q;
  logic                  first_access;
  logic                  valid_start;
  logic                  bad_start;

  for (genvar t = 0; t < `RAM_TILES; t++) begin : gen_valid
    assign tile_valid[t] = tile_req[t].valid;
  end

  // -------------------------------------------------------------------
  // First access cycle tracking
  // -------------------------------------------------------------------
  assign access = psel && penable;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_transfer_q <= 1'b0;
    end else begin
      in_transfer_q <= access && !pready;
    end
  end

  assign first_access = access && !in_transfer_q;
  assign valid_start  = first_access && (paddr[1:0] == 2'b00);
  assign bad_start    = first_access && (paddr[1:0] != 2'b00);

  // -------------------------------------------------------------------
  // Handshake and latency
  // -------------------------------------------------------------------
  a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    valid_start |-> !pready ##ready_delay pready)
    else begin
      $error("PREADY not seen at the expected access cycle");
      fail_count++;
    end

  a_error_first_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    bad_start |-> pready && pslverr)
    else begin
      $error("misaligned access not answered with PSLVERR in its first access cycle");
      fail_count++;
    end

  a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !access |-> !pready && !pslverr)
    else begin
      $error("PREADY or PSLVERR high outside an access");
      fail_count++;
    end

  a_reset_exit: assert property (@(posedge clk) $rose(rst_n) |-> !pready && !pslverr)
    else begin
      $error("PREADY or PSLVERR high right after reset");
      fail_count++;
    end

  // -------------------------------------------------------------------
  // Tile side
  // -------------------------------------------------------------------
  a_tile_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(tile_valid))
    else begin
      $error("more than one tile request valid");
      fail_count++;
    end

  a_no_collision: assert property (@(posedge clk) disable iff (!rst_n) !collision)
    else begin
      $error("two tiles completed in the same cycle");
      fail_count++;
    end

endmodule : apb_tiled_ram_assert

bind apb_tiled_ram apb_tiled_ram_assert apb_tiled_ram_assert_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .psel     (psel),
  .penable  (penable),
  .pready   (pready),
  .pslverr  (pslverr),
  .paddr    (paddr),
  .tile_req (tile_req),
  .collision(collision)
);

`default_nettype wire

// ==== tb/tb_apb_tiled_ram.sv ====
// -------------------------------------------------------------------
// Drives APB on the falling edge and samples 1 ns later in the same cycle
// Reference memory only checks words that were written
// -------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "tiled_ram_macros.svh"

module tb_apb_tiled_ram;

  localparam int depth = `RAM_DEPTH;
  localparam int data_width = `RAM_DATA_WIDTH;
  // Decoder latency of stages minus one plus the tile register
  localparam int ready_cycle = (`RAM_STAGES - 1) + 1;
  localparam int max_wait = 4 * ready_cycle;
  // Longest test is 200 random transfers of at most 8 cycles
  localparam int test_cycle_limit = 2000;
  localparam int random_ops = 200;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [7:0]            paddr;
  logic [data_width-1:0] pwdata;
  logic [data_width-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  // Reference model
  logic [data_width-1:0] ref_mem [depth];
  bit                    ref_written [depth];

  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          test_first_error = 0;
  int          cycle_count = 0;
  int          test_start_cycle = 0;
  string       test_name = "reset";
  int unsigned assert_failures;

  apb_tiled_ram apb_tiled_ram_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr(pslverr)
  );

  always #10 clk = ~clk;

  // Per-test cycle watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count - test_start_cycle > test_cycle_limit) begin
      $display("Timeout: test %s ran past %0d cycles", test_name, test_cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // -------------------------------------------------------------------
  // Bookkeeping
  // -------------------------------------------------------------------
  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_first_error = errors;
    test_start_cycle = cycle_count;
  endtask

  task automatic finish_test();
    if (errors == test_first_error) begin
      tests_passed++;
      $display("Test %s: pass", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL with %0d errors", test_name, errors - test_first_error);
    end
  endtask

  // Word pattern that mixes every address bit
  function automatic logic [data_width-1:0] fill_word(input int word);
    return data_width'((32'(word) * 32'h9E37_79B1) ^ 32'hC0DE_0000 ^ 32'(word));
  endfunction

  // -------------------------------------------------------------------
  // APB driver
  // -------------------------------------------------------------------
  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  // Setup cycle followed by access cycles until PREADY
  // lat counts the access cycles before PREADY
  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [data_width-1:0] wdata,
                              output logic [data_width-1:0] rdata,
                              output logic err, output int lat);
    bit done;
    done  = 1'b0;
    lat   = 0;
    rdata = '0;
    err   = 1'b0;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    while (!done && lat <= max_wait) begin
      #1;
      if (pready) begin
        done  = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end else begin
        lat++;
        @(negedge clk);
      end
    end
    if (!done) begin
      report_error($sformatf("no PREADY within %0d cycles for address %h", max_wait, addr));
    end
  endtask

  task automatic write_word(input int word, input logic [data_width-1:0] data);
    logic [data_width-1:0] rdata;
    logic                  err;
    int                    lat;
    apb_transfer(1'b1, 8'(word << 2), data, rdata, err, lat);
    assert (!err && rdata == '0)
      else report_error($sformatf("write to word %0d gave pslverr %b prdata %h", word, err, rdata));
    assert (lat == ready_cycle)
      else report_error($sformatf("write to word %0d ended in access cycle %0d", word, lat));
    ref_mem[word]     = data;
    ref_written[word] = 1'b1;
  endtask

  task automatic read_word(input int word);
    logic [data_width-1:0] rdata;
    logic                  err;
    int                    lat;
    apb_transfer(1'b0, 8'(word << 2), '0, rdata, err, lat);
    assert (!err) else report_error($sformatf("read of word %0d gave pslverr", word));
    assert (lat == ready_cycle)
      else report_error($sformatf("read of word %0d ended in access cycle %0d", word, lat));
    if (ref_written[word]) begin
      assert (rdata == ref_mem[word])
        else report_error($sformatf("word %0d read %h, expected %h", word, rdata, ref_mem[word]));
    end
  endtask

  // Misaligned access ends at once with an error and must not touch memory
  task automatic misaligned_access(input logic write, input logic [7:0] addr);
    logic [data_width-1:0] rdata;
    logic                  err;
    int                    lat;
    apb_transfer(write, addr, ~fill_word(int'(addr)), rdata, err, lat);
    assert (err && lat == 0)
      else report_error($sformatf("address %h gave pslverr %b in access cycle %0d", addr, err, lat));
    assert (rdata == '0) else report_error($sformatf("address %h returned prdata %h", addr, rdata));
  endtask

  // -------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------
  initial begin
    int word;
    int gap;
    void'($urandom(64));
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test("reset_idle");
    repeat (5) begin
      @(negedge clk);
      #1;
      assert (!pready && !pslverr) else report_error("pready or pslverr high on an idle bus");
    end
    finish_test();

    start_test("fill_and_readback");
    for (int w = 0; w < depth; w++) begin
      write_word(w, fill_word(w));
    end
    for (int w = 0; w < depth; w++) begin
      read_word(w);
    end
    finish_test();

    start_test("write_then_read");
    write_word(5, 32'h1234_5678);
    read_word(5);
    write_word(42, 32'hDEAD_BEEF);
    write_word(42, 32'h0BAD_F00D);
    read_word(42);
    finish_test();

    start_test("misaligned");
    for (int off = 1; off < 4; off++) begin
      misaligned_access(1'b1, 8'((17 << 2) + off));
      misaligned_access(1'b0, 8'((17 << 2) + off));
    end
    read_word(17);
    finish_test();

    start_test("latency");
    // Back to back writes of one word per tile
    for (int i = 0; i < 8; i++) begin
      write_word(i * 9, fill_word(i * 9) ^ 32'h0F0F_0F0F);
    end
    for (int i = 0; i < 8; i++) begin
      idle(1 + (i % 3));
      read_word(i * 9);
    end
    finish_test();

    start_test("random");
    for (int i = 0; i < random_ops; i++) begin
      word = int'($urandom_range(depth - 1, 0));
      gap  = int'($urandom_range(3, 0));
      if ($urandom_range(1, 0) == 1) begin
        write_word(word, $urandom);
      end else begin
        read_word(word);
      end
      idle(gap);
    end
    finish_test();

    idle(2);
    assert_failures = apb_tiled_ram_inst.apb_tiled_ram_assert_inst.fail_count;
    $display("Tests passed: %0d, tests failed: %0d, assertion failures: %0d",
             tests_passed, tests_failed, assert_failures);
    if (tests_failed == 0 && errors == 0 && assert_failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_apb_tiled_ram

`default_nettype wire
